//--- Bender.yml
package:
  name: mmcam_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mmcam_pkg.sv
      - design/packet_receiver.sv
      - design/matching_memory.sv
      - design/pair_sender.sv
      - design/mmcam_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/mmcam_stage_assert.sv
      - verification/mmcam_stage_tb.sv

//--- design/matching_memory.sv
`default_nettype none

`include "mmcam_params.svh"

module matching_memory (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       bufValid,
    input  wire mmcam_pkg::mmcamPacket      bufPacket,
    input  wire logic                       senderFree,
    output logic                            take,
    output logic                            resValid,
    output mmcam_pkg::mmcamPacket           resPacket,
    output logic [`MMCAM_DATA_W-1:0]        resPartner,
    output logic                            resPaired
);

    import mmcam_pkg::*;

    localparam int slotCount = 1 << `MMRAM_ADDR_W;

    // Direct-mapped store, one waiting operand per slot
    logic [slotCount-1:0]     slotValid;
    logic [`MMCAM_KEY_W-1:0]  slotKey  [slotCount];
    logic                     slotLr   [slotCount];
    logic [`MMCAM_OFS_W-1:0]  slotOfs  [slotCount];
    logic [`MMCAM_DATA_W-1:0] slotData [slotCount];

    logic [`MMRAM_ADDR_W-1:0] addr;
    logic                     keyHit;
    logic                     isPair;
    logic                     doStore;
    logic                     incomingRight;
    logic [`MMCAM_DATA_W-1:0] leftData;
    logic [`MMCAM_DATA_W-1:0] rightData;
    logic [`MMCAM_OFS_W-1:0]  leftOfs;

    assign addr = mmcamHash(bufPacket.fields.gen, bufPacket.fields.node);

    assign keyHit = slotValid[addr] && (slotKey[addr] == bufPacket.keyView.key);

    // Partner found only when it sits on the other side
    assign isPair = bufPacket.fields.mf && keyHit &&
                    (slotLr[addr] != bufPacket.fields.lr);

    assign doStore = bufPacket.fields.mf && !slotValid[addr];

    assign take = bufValid && senderFree;

    // A stored token produces no output, everything else does
    assign resValid  = take && !doStore;
    assign resPaired = isPair;

    assign incomingRight = bufPacket.fields.lr;

    assign leftData  = incomingRight ? slotData[addr] : bufPacket.fields.data;
    assign rightData = incomingRight ? bufPacket.fields.data : slotData[addr];
    assign leftOfs   = incomingRight ? slotOfs[addr] : bufPacket.fields.ofs;

    always_comb begin
        resPacket  = bufPacket;  // Forwarded tokens leave unchanged
        resPartner = '0;
        if (isPair) begin
            resPacket.fields.ofs  = leftOfs;
            resPacket.fields.lr   = 1'b0;
            resPacket.fields.mf   = 1'b0;
            resPacket.fields.data = leftData;
            resPartner            = rightData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            slotValid <= '0;
        end else if (take) begin
            if (doStore) begin
                slotValid[addr] <= 1'b1;
            end else if (isPair) begin
                slotValid[addr] <= 1'b0;  // Slot freed once the pair fires
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && doStore) begin
            slotKey[addr]  <= bufPacket.keyView.key;
            slotLr[addr]   <= bufPacket.fields.lr;
            slotOfs[addr]  <= bufPacket.fields.ofs;
            slotData[addr] <= bufPacket.fields.data;
        end
    end

endmodule

`default_nettype wire

//--- design/mmcam_params.svh
`ifndef MMCAM_PARAMS_SVH
`define MMCAM_PARAMS_SVH

// Token field widths, most significant field first in the token word
`define MMCAM_GEN_W 3
`define MMCAM_NODE_W 8
`define MMCAM_OFS_W 7
`define MMCAM_DATA_W 18

// The matching key is generation plus destination node
`define MMCAM_KEY_W (`MMCAM_GEN_W + `MMCAM_NODE_W)

// gen + node + ofs + lr + mf + data
`define MMCAM_PACKET_W (`MMCAM_KEY_W + `MMCAM_OFS_W + 2 + `MMCAM_DATA_W)

// 64 slots in the matching memory
`define MMRAM_ADDR_W 6

`endif

//--- design/mmcam_pkg.sv
`default_nettype none

`include "mmcam_params.svh"

package mmcam_pkg;

    typedef struct packed {
        logic [`MMCAM_GEN_W-1:0]  gen;
        logic [`MMCAM_NODE_W-1:0] node;
        logic [`MMCAM_OFS_W-1:0]  ofs;
        logic                     lr;   // Set for the right operand
        logic                     mf;   // Set when the token waits for a partner
        logic [`MMCAM_DATA_W-1:0] data;
    } mmcamFields;

    // Same word seen as the matching key followed by everything else
    typedef struct packed {
        logic [`MMCAM_KEY_W-1:0]                  key;
        logic [`MMCAM_PACKET_W-`MMCAM_KEY_W-1:0] rest;
    } mmcamKeyView;

    typedef union packed {
        mmcamFields  fields;
        mmcamKeyView keyView;
    } mmcamPacket;

    // Node bits folded with gen placed in the top address bits
    function automatic logic [`MMRAM_ADDR_W-1:0] mmcamHash(
        input logic [`MMCAM_GEN_W-1:0]  gen,
        input logic [`MMCAM_NODE_W-1:0] node
    );
        logic [`MMRAM_ADDR_W-1:0] genHigh;
        genHigh = {gen, {(`MMRAM_ADDR_W - `MMCAM_GEN_W){1'b0}}};
        return node[`MMRAM_ADDR_W-1:0] ^ genHigh;
    endfunction

endpackage

`default_nettype wire

//--- design/mmcam_stage.sv
`default_nettype none

`include "mmcam_params.svh"

module mmcam_stage (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       sendIn,
    input  wire mmcam_pkg::mmcamPacket      packetIn,
    input  wire logic                       ackIn,
    output logic                            ackOut,
    output logic                            sendOut,
    output mmcam_pkg::mmcamPacket           packetOut,
    output logic [`MMCAM_DATA_W-1:0]        partnerOut,
    output logic                            paired
);

    import mmcam_pkg::*;

    logic                     bufValid;
    mmcamPacket               bufPacket;
    logic                     take;
    logic                     senderFree;
    logic                     resValid;
    mmcamPacket               resPacket;
    logic [`MMCAM_DATA_W-1:0] resPartner;
    logic                     resPaired;

    packet_receiver u_receiver (
        .clk       (clk),
        .rstN      (rstN),
        .sendIn    (sendIn),
        .packetIn  (packetIn),
        .take      (take),
        .ackOut    (ackOut),
        .bufValid  (bufValid),
        .bufPacket (bufPacket)
    );

    matching_memory u_memory (
        .clk        (clk),
        .rstN       (rstN),
        .bufValid   (bufValid),
        .bufPacket  (bufPacket),
        .senderFree (senderFree),
        .take       (take),
        .resValid   (resValid),
        .resPacket  (resPacket),
        .resPartner (resPartner),
        .resPaired  (resPaired)
    );

    pair_sender u_sender (
        .clk        (clk),
        .rstN       (rstN),
        .resValid   (resValid),
        .resPacket  (resPacket),
        .resPartner (resPartner),
        .resPaired  (resPaired),
        .ackIn      (ackIn),
        .senderFree (senderFree),
        .sendOut    (sendOut),
        .packetOut  (packetOut),
        .partnerOut (partnerOut),
        .paired     (paired)
    );

endmodule

`default_nettype wire

//--- design/packet_receiver.sv
`default_nettype none

module packet_receiver (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 sendIn,
    input  wire mmcam_pkg::mmcamPacket packetIn,
    input  wire logic                 take,
    output logic                      ackOut,
    output logic                      bufValid,
    output mmcam_pkg::mmcamPacket     bufPacket
);

    logic capture;

    // A token still held after its ack must not be captured a second time
    assign capture = sendIn && !bufValid && !ackOut;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ackOut   <= 1'b0;
            bufValid <= 1'b0;
        end else begin
            ackOut <= capture;  // One pulse per captured token
            if (capture) begin
                bufValid <= 1'b1;
            end else if (take) begin
                bufValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            bufPacket <= packetIn;
        end
    end

endmodule

`default_nettype wire

//--- design/pair_sender.sv
`default_nettype none

`include "mmcam_params.svh"

module pair_sender (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       resValid,
    input  wire mmcam_pkg::mmcamPacket      resPacket,
    input  wire logic [`MMCAM_DATA_W-1:0]   resPartner,
    input  wire logic                       resPaired,
    input  wire logic                       ackIn,
    output logic                            senderFree,
    output logic                            sendOut,
    output mmcam_pkg::mmcamPacket           packetOut,
    output logic [`MMCAM_DATA_W-1:0]        partnerOut,
    output logic                            paired
);

    // The register takes a new result only after the last one was acknowledged
    assign senderFree = !sendOut;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sendOut <= 1'b0;
        end else if (resValid) begin
            sendOut <= 1'b1;
        end else if (ackIn) begin
            sendOut <= 1'b0;  // Ack completes the transfer at this edge
        end
    end

    // Outputs stay stable while sendOut waits for ackIn
    always_ff @(posedge clk) begin
        if (resValid) begin
            packetOut  <= resPacket;
            partnerOut <= resPartner;
            paired     <= resPaired;
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/mmcam_pkg.sv
design/packet_receiver.sv
design/matching_memory.sv
design/pair_sender.sv
design/mmcam_stage.sv
verification/mmcam_stage_assert.sv
verification/mmcam_stage_tb.sv

//--- verification/mmcam_stage_assert.sv
`default_nettype none

`include "mmcam_params.svh"

module mmcam_stage_assert (
    input wire logic                      clk,
    input wire logic                      rstN,
    input wire logic                      ackOut,
    input wire logic                      sendOut,
    input wire logic                      ackIn,
    input wire mmcam_pkg::mmcamPacket     packetOut,
    input wire logic [`MMCAM_DATA_W-1:0]  partnerOut,
    input wire logic                      paired
);

    // One acknowledge pulse per captured token
    ackSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
        ackOut |=> !ackOut)
        else $error("ackOut high two cycles in a row");

    outputHold: assert property (@(posedge clk) disable iff (!rstN)
        (sendOut && !ackIn) |=> ($stable(packetOut) && $stable(partnerOut) && $stable(paired)))
        else $error("Output token changed before ackIn");

    resetIdle: assert property (@(posedge clk)
        !rstN |=> !sendOut)
        else $error("sendOut high after reset");

endmodule

bind mmcam_stage mmcam_stage_assert u_assert (
    .clk        (clk),
    .rstN       (rstN),
    .ackOut     (ackOut),
    .sendOut    (sendOut),
    .ackIn      (ackIn),
    .packetOut  (packetOut),
    .partnerOut (partnerOut),
    .paired     (paired)
);

`default_nettype wire

//--- verification/mmcam_stage_tb.sv
`default_nettype none

`include "mmcam_params.svh"

module mmcam_stage_tb;

    import mmcam_pkg::*;

    localparam int testCycles    = 200;
    localparam int timeoutCycles = 10 * testCycles;

    logic                     clk;
    logic                     rstN;
    logic                     sendIn;
    mmcamPacket               packetIn;
    logic                     ackIn;
    logic                     ackOut;
    logic                     sendOut;
    mmcamPacket               packetOut;
    logic [`MMCAM_DATA_W-1:0] partnerOut;
    logic                     paired;
    integer                   seed = 32'hd4f9_23c9;
    int                       waitCycles;

    mmcam_stage u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .sendIn     (sendIn),
        .packetIn   (packetIn),
        .ackIn      (ackIn),
        .ackOut     (ackOut),
        .sendOut    (sendOut),
        .packetOut  (packetOut),
        .partnerOut (partnerOut),
        .paired     (paired)
    );

    always #50 clk = ~clk;

    task automatic checkPacket(input string name, input mmcamPacket exp, input mmcamPacket act);
        if (act !== exp) begin
            $display("[ERROR] time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Token mismatch");
        end
    endtask

    task automatic checkData(input string name, input logic [`MMCAM_DATA_W-1:0] exp,
                             input logic [`MMCAM_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Operand mismatch");
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] time=%0t %s expected=%b actual=%b", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Control bit mismatch");
        end
    endtask

    task automatic checkTrue(input bit cond, input string what);
        if (!cond) begin
            $display("Failure at time %0t: %s", $time, what);
            $display("Test FAILED");
            $fatal(1, "Condition not met");
        end
    endtask

    function automatic logic [`MMCAM_DATA_W-1:0] nextData();
        logic [31:0] r;
        r = $random(seed);
        return r[`MMCAM_DATA_W-1:0];
    endfunction

    function automatic mmcamPacket makeToken(input logic [`MMCAM_GEN_W-1:0] gen,
                                             input logic [`MMCAM_NODE_W-1:0] node,
                                             input logic [`MMCAM_OFS_W-1:0] ofs,
                                             input logic lr, input logic mf);
        mmcamPacket tok;
        tok.fields.gen  = gen;
        tok.fields.node = node;
        tok.fields.ofs  = ofs;
        tok.fields.lr   = lr;
        tok.fields.mf   = mf;
        tok.fields.data = nextData();
        return tok;
    endfunction

    // Pair keeps the left operand's key, offset and data with both flags cleared
    function automatic mmcamPacket expectedPair(input mmcamPacket left);
        mmcamPacket tok;
        tok           = left;
        tok.fields.lr = 1'b0;
        tok.fields.mf = 1'b0;
        return tok;
    endfunction

    // Gen lands on the top three address bits, node supplies the rest
    function automatic logic [`MMRAM_ADDR_W-1:0] slotOf(input mmcamPacket tok);
        return {tok.fields.node[`MMRAM_ADDR_W-1:`MMRAM_ADDR_W-`MMCAM_GEN_W] ^ tok.fields.gen,
                tok.fields.node[`MMRAM_ADDR_W-`MMCAM_GEN_W-1:0]};
    endfunction

    task automatic sendToken(input mmcamPacket tok);
        sendIn   = 1'b1;
        packetIn = tok;
        do @(negedge clk); while (!ackOut);
        sendIn = 1'b0;
    endtask

    task automatic waitOutput(input mmcamPacket expPacket, input logic [`MMCAM_DATA_W-1:0] expPartner,
                              input logic expPaired, input int ackDelay);
        int heldCycles;
        heldCycles = 0;
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
        end while (!sendOut);
        checkPacket("packetOut", expPacket, packetOut);
        checkBit("paired", expPaired, paired);
        if (expPaired) begin
            checkData("partnerOut", expPartner, partnerOut);
        end
        repeat (ackDelay) begin
            @(negedge clk);
            heldCycles++;
            if (heldCycles >= 2) begin
                checkBit("ackOut", 1'b0, ackOut);  // Input buffer is full by now
            end
        end
        ackIn = 1'b1;
        @(negedge clk);
        ackIn = 1'b0;
    endtask

    task automatic expectSilence(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkBit("sendOut", 1'b0, sendOut);
        end
    endtask

    task automatic testReset();
        repeat (4) begin
            @(negedge clk);
            checkBit("sendOut", 1'b0, sendOut);
            checkBit("ackOut", 1'b0, ackOut);
        end
    endtask

    task automatic testPassThrough();
        mmcamPacket tok;
        tok = makeToken(3'd1, 8'h5a, 7'h33, 1'b1, 1'b0);
        sendToken(tok);
        waitOutput(tok, '0, 1'b0, 2);
        checkTrue(waitCycles == 1, "sendOut did not rise one cycle after ackOut");
    endtask

    task automatic testMatching();
        mmcamPacket left;
        mmcamPacket right;
        left  = makeToken(3'd2, 8'h31, 7'h11, 1'b0, 1'b1);
        right = makeToken(3'd2, 8'h31, 7'h22, 1'b1, 1'b1);
        sendToken(left);
        expectSilence(4);
        sendToken(right);
        waitOutput(expectedPair(left), right.fields.data, 1'b1, 0);
        left  = makeToken(3'd3, 8'h44, 7'h06, 1'b0, 1'b1);
        right = makeToken(3'd3, 8'h44, 7'h05, 1'b1, 1'b1);
        sendToken(right);  // Right operand first this time
        expectSilence(4);
        sendToken(left);
        waitOutput(expectedPair(left), right.fields.data, 1'b1, 1);
    endtask

    task automatic testDeleteAndCollision();
        mmcamPacket               again;
        mmcamPacket               resident;
        mmcamPacket               intruder;
        logic [`MMRAM_ADDR_W-1:0] slot;
        again = makeToken(3'd2, 8'h31, 7'h40, 1'b0, 1'b1);
        sendToken(again);  // Slot was freed by the earlier pair
        expectSilence(4);
        resident = makeToken(3'd5, 8'h0a, 7'h12, 1'b0, 1'b1);
        sendToken(resident);
        expectSilence(4);
        slot = slotOf(resident);
        // Other gen, node chosen so the hash lands on the resident's slot
        intruder = makeToken(3'd2, {2'b00, slot[5:3] ^ 3'd2, slot[2:0]}, 7'h13, 1'b1, 1'b1);
        sendToken(intruder);
        waitOutput(intruder, '0, 1'b0, 0);
        intruder = makeToken(3'd5, 8'h0a, 7'h14, 1'b0, 1'b1);
        sendToken(intruder);  // Same key and same side as the resident
        waitOutput(intruder, '0, 1'b0, 0);
    endtask

    task automatic testBackPressure();
        mmcamPacket tokens [5];
        int         delays [5];
        for (int i = 0; i < 5; i++) begin
            tokens[i] = makeToken(3'd6, 8'h80 + 8'(i), 7'(i), 1'b0, 1'b0);
            delays[i] = 1 + ($random(seed) & 7);
        end
        fork
            begin
                for (int i = 0; i < 5; i++) begin
                    sendToken(tokens[i]);
                end
            end
            begin
                for (int i = 0; i < 5; i++) begin
                    waitOutput(tokens[i], '0, 1'b0, delays[i]);
                end
            end
        join
        expectSilence(4);
    endtask

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", timeoutCycles);
        $display("Test FAILED");
        $fatal(1, "Run stopped by the watchdog");
    end

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        sendIn   = 1'b0;
        packetIn = '0;
        ackIn    = 1'b0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        testReset();
        testPassThrough();
        testMatching();
        testDeleteAndCollision();
        testBackPressure();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
